// ==== include/rv_exec_macros.svh ====
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// Width of a data word and of every address in the core
`define XLEN_W 32

// Five bits address the 32 integer registers
`define REG_IDX_W 5

// Byte distance to the next sequential instruction, used for the link value
`define PC_STEP 4

`endif

// ==== project.f ====
+incdir+include
src/rv_exec_pkg.sv
src/forward_unit.sv
src/operand_select.sv
src/alu.sv
src/branch_unit.sv
src/execute_stage.sv
src/exec_top.sv
verification/exec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module exec_tb
./obj_dir/Vexec_tb > sim.log
cat sim.log
if grep -q "^Test OK$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== src/alu.sv ====
`timescale 1ns/10ps

module alu
    import rv_exec_pkg::*;
(
    input  alu_op_t alu_op,
    input  word_t   op_a,
    input  word_t   op_b,
    output word_t   result
);

    logic [4:0] shamt;       // RV32I shifts look at five bits only
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = op_b[4:0];
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb
    begin
        case (alu_op)
            ALU_ADD:
                result = op_a + op_b;
            ALU_SUB:
                result = op_a - op_b;
            ALU_SLL:
                result = op_a << shamt;
            ALU_SLT:
                result = word_t'(lt_signed);   // One or zero
            ALU_SLTU:
                result = word_t'(lt_unsigned);
            ALU_XOR:
                result = op_a ^ op_b;
            ALU_SRL:
                result = op_a >> shamt;
            ALU_SRA:
                result = word_t'($signed(op_a) >>> shamt); // Sign bit fills from the left
            ALU_OR:
                result = op_a | op_b;
            ALU_AND:
                result = op_a & op_b;
            default:
            begin
                // Unused codes fall back to an add
                result = op_a + op_b;
            end
        endcase
    end

endmodule

// ==== src/branch_unit.sv ====
`timescale 1ns/10ps

module branch_unit
    import rv_exec_pkg::*;
(
    input  op_class_t op_class,
    input  br_cond_t  br_cond,
    input  word_t     pc,
    input  word_t     imm,
    input  word_t     rs1,
    input  word_t     rs2,
    output logic      taken,    // Raw decision, the stage qualifies it with valid and stall
    output word_t     target
);

    logic cond_met;

    // Compare the forwarded register values for the branch condition
    always_comb
    begin
        case (br_cond)
            BR_BEQ:  cond_met = (rs1 == rs2);
            BR_BNE:  cond_met = (rs1 != rs2);
            BR_BLT:  cond_met = ($signed(rs1) < $signed(rs2));
            BR_BGE:  cond_met = ($signed(rs1) >= $signed(rs2));
            BR_BLTU: cond_met = (rs1 < rs2);
            BR_BGEU: cond_met = (rs1 >= rs2);
            default: cond_met = 1'b0;   // Reserved funct3 codes never branch
        endcase
    end

    always_comb
    begin
        taken  = 1'b0;
        target = pc + imm;              // PC relative for branches and JAL
        case (op_class)
            CLS_BRANCH: taken = cond_met;
            CLS_JAL:    taken = 1'b1;
            CLS_JALR:
            begin
                taken  = 1'b1;
                target = (rs1 + imm) & ~word_t'(1); // Bit zero is cleared by the ISA
            end
            default:    taken = 1'b0;
        endcase
    end

endmodule

// ==== src/exec_top.sv ====
`timescale 1ns/10ps

module exec_top
    import rv_exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,       // Global pipeline hold
    input  id_ex_t    id_in,       // Decoded instruction from decode
    input  wb_fwd_t   wb_in,       // Register file write in progress
    output ex_mem_t   ex_mem_out,  // To the memory stage
    output redirect_t redirect     // To fetch
);

    id_ex_t id_ex;     // Instruction sitting in execute
    word_t  rs1_fwd;
    word_t  rs2_fwd;

    // The EX/MEM output loops back as the nearest bypass source
    forward_unit u_forward_unit (
        .id_ex   (id_ex),
        .ex_mem  (ex_mem_out),
        .wb      (wb_in),
        .rs1_fwd (rs1_fwd),
        .rs2_fwd (rs2_fwd)
    );

    execute_stage u_execute_stage (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .id_in      (id_in),
        .rs1_fwd    (rs1_fwd),
        .rs2_fwd    (rs2_fwd),
        .id_ex      (id_ex),
        .ex_mem_out (ex_mem_out),
        .redirect   (redirect)
    );

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/10ps

`include "rv_exec_macros.svh"

module execute_stage
    import rv_exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,      // Holds both registers when high
    input  id_ex_t    id_in,      // From decode
    input  word_t     rs1_fwd,    // Bypassed sources from the forward unit
    input  word_t     rs2_fwd,
    output id_ex_t    id_ex,      // Current ID/EX contents for forwarding
    output ex_mem_t   ex_mem_out,
    output redirect_t redirect
);

    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_q;
    ex_mem_t ex_mem_d;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_result;
    word_t   br_target;
    logic    br_taken;
    logic    is_jump;

    operand_select u_operand_select (
        .op_class (id_ex_q.op_class),
        .pc       (id_ex_q.pc),
        .imm      (id_ex_q.imm),
        .rs1      (rs1_fwd),
        .rs2      (rs2_fwd),
        .op_a     (op_a),
        .op_b     (op_b)
    );

    alu u_alu (
        .alu_op (id_ex_q.alu_op),
        .op_a   (op_a),
        .op_b   (op_b),
        .result (alu_result)
    );

    branch_unit u_branch_unit (
        .op_class (id_ex_q.op_class),
        .br_cond  (id_ex_q.br_cond),
        .pc       (id_ex_q.pc),
        .imm      (id_ex_q.imm),
        .rs1      (rs1_fwd),
        .rs2      (rs2_fwd),
        .taken    (br_taken),
        .target   (br_target)
    );

    assign is_jump = (id_ex_q.op_class == CLS_JAL) || (id_ex_q.op_class == CLS_JALR);

    // A held instruction does not redirect, it fires once when the stall drops
    assign redirect.taken  = id_ex_q.valid && !stall && br_taken;
    assign redirect.target = br_target;

    always_comb
    begin
        ex_mem_d.valid      = id_ex_q.valid;
        ex_mem_d.result     = is_jump ? id_ex_q.pc + word_t'(`PC_STEP) : alu_result; // Link value
        ex_mem_d.store_data = rs2_fwd;
        ex_mem_d.rd_idx     = id_ex_q.rd_idx;
        // A bubble must not touch memory or the register file
        ex_mem_d.mem_read   = id_ex_q.valid && id_ex_q.mem_read;
        ex_mem_d.mem_write  = id_ex_q.valid && id_ex_q.mem_write;
        ex_mem_d.reg_write  = id_ex_q.valid && id_ex_q.reg_write;
        ex_mem_d.mem_to_reg = id_ex_q.valid && id_ex_q.mem_to_reg;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            id_ex_q  <= '0;
            ex_mem_q <= '0;
        end
        else if (!stall)
        begin
            id_ex_q  <= id_in;
            ex_mem_q <= ex_mem_d;
            // Wrong-path instruction behind a taken redirect becomes a bubble
            if (redirect.taken)
                id_ex_q.valid <= 1'b0;
        end
    end

    assign id_ex      = id_ex_q;
    assign ex_mem_out = ex_mem_q;

endmodule

// ==== src/forward_unit.sv ====
`timescale 1ns/10ps

module forward_unit
    import rv_exec_pkg::*;
(
    input  id_ex_t  id_ex,   // Instruction now in execute
    input  ex_mem_t ex_mem,  // Instruction one stage ahead
    input  wb_fwd_t wb,      // Instruction two stages ahead, being written back
    output word_t   rs1_fwd,
    output word_t   rs2_fwd
);

    // Newest copy of one source register
    // The EX/MEM result wins over writeback since it is younger
    function automatic word_t pick_newest(
        input reg_idx_t src_idx,
        input word_t    rf_val,
        input ex_mem_t  ahead,
        input wb_fwd_t  back
    );
        logic hit_ahead;
        logic hit_back;
        // A load has no data yet in EX/MEM, decode stalls for that case
        hit_ahead = ahead.valid && ahead.reg_write && !ahead.mem_read
                    && (ahead.rd_idx == src_idx);
        hit_back  = back.valid && (back.rd_idx == src_idx);
        if (src_idx == '0)
            return rf_val; // x0 never takes a bypassed value
        else if (hit_ahead)
            return ahead.result;
        else if (hit_back)
            return back.value;
        else
            return rf_val;
    endfunction

    always_comb
    begin
        rs1_fwd = pick_newest(id_ex.rs1_idx, id_ex.rs1_val, ex_mem, wb);
        rs2_fwd = pick_newest(id_ex.rs2_idx, id_ex.rs2_val, ex_mem, wb); // Also feeds store data
    end

endmodule

// ==== src/operand_select.sv ====
`timescale 1ns/10ps

module operand_select
    import rv_exec_pkg::*;
(
    input  op_class_t op_class,
    input  word_t     pc,
    input  word_t     imm,
    input  word_t     rs1,      // Already forwarded
    input  word_t     rs2,      // Already forwarded
    output word_t     op_a,
    output word_t     op_b
);

    // The enum fills all eight codes, so every class is listed
    always_comb
    begin
        case (op_class)
            CLS_MEM:
            begin
                op_a = rs1;     // Effective address base
                op_b = imm;
            end
            CLS_BRANCH,
            CLS_ALU_REG:
            begin
                op_a = rs1;
                op_b = rs2;
            end
            CLS_ALU_IMM,
            CLS_JALR:
            begin
                // The ALU value is unused for JALR, the branch unit makes the target
                op_a = rs1;
                op_b = imm;
            end
            CLS_LUI:
            begin
                op_a = '0;      // Zero plus imm passes the upper immediate through
                op_b = imm;
            end
            CLS_AUIPC,
            CLS_JAL:
            begin
                op_a = pc;
                op_b = imm;
            end
            default:
            begin
                op_a = rs1;
                op_b = rs2;
            end
        endcase
    end

endmodule

// ==== src/rv_exec_pkg.sv ====
`include "rv_exec_macros.svh"

package rv_exec_pkg;

    typedef logic [`XLEN_W-1:0]    word_t;    // Data word or byte address
    typedef logic [`REG_IDX_W-1:0] reg_idx_t; // Register index, x0 is hardwired to zero

    // Instruction class, picks the ALU operands and the kind of target
    typedef enum logic [2:0] {
        CLS_MEM     = 3'd0, // Load or store, address is rs1 plus imm
        CLS_BRANCH  = 3'd1,
        CLS_ALU_REG = 3'd2,
        CLS_ALU_IMM = 3'd3,
        CLS_LUI     = 3'd4, // Immediate arrives already shifted into the upper bits
        CLS_AUIPC   = 3'd5,
        CLS_JAL     = 3'd6,
        CLS_JALR    = 3'd7
    } op_class_t;

    // Bit 3 mirrors funct7[5] and the low bits mirror funct3
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_t;

    // Encoded as the funct3 field of the branch instructions
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_cond_t;

    // One decoded instruction as decode hands it over
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     imm;
        reg_idx_t  rs1_idx;
        word_t     rs1_val;    // Register file read, may be stale
        reg_idx_t  rs2_idx;
        word_t     rs2_val;
        reg_idx_t  rd_idx;
        op_class_t op_class;
        alu_op_t   alu_op;
        br_cond_t  br_cond;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      mem_to_reg;
    } id_ex_t;

    // What the memory stage receives from execute
    typedef struct packed {
        logic     valid;
        word_t    result;      // ALU value, memory address or link value
        word_t    store_data;
        reg_idx_t rd_idx;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     mem_to_reg;
    } ex_mem_t;

    // Value being written back to the register file this cycle
    typedef struct packed {
        logic     valid;
        reg_idx_t rd_idx;
        word_t    value;
    } wb_fwd_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

// ==== verification/exec_tb.sv ====
`timescale 1ns/10ps

`include "rv_exec_macros.svh"

module exec_tb
    import rv_exec_pkg::*;
();

    localparam int NUM_RANDOM = 200;
    localparam int MAX_CYCLES = 400;   // Roughly 250 cycles of tests with stalls, plus margin

    localparam alu_op_t ALU_OPS [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                                          ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};
    localparam br_cond_t CONDS [6] = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

    logic      clk;
    logic      rst;
    logic      stall;
    id_ex_t    id_in;
    wb_fwd_t   wb_in;
    ex_mem_t   ex_mem_out;
    redirect_t redirect;

    word_t      rf [32];      // Register file that the testbench plays for decode
    id_ex_t     m_ex;         // Model of the ID/EX register
    ex_mem_t    m_mem;        // Model of the EX/MEM register, compared against the DUT
    wb_fwd_t    m_wb;         // Model of the writeback stage, it also drives wb_in
    ex_mem_t    exp_next;     // EX/MEM contents expected after the next unstalled edge
    logic       exp_taken;
    word_t      exp_target;
    word_t      next_pc;      // Fetch address of the next instruction decode hands over
    logic [4:0] ctrl_dut;
    logic [4:0] ctrl_exp;
    integer     seed;
    int         errors;
    int         cycle_count;

    exec_top UUT (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .id_in      (id_in),
        .wb_in      (wb_in),
        .ex_mem_out (ex_mem_out),
        .redirect   (redirect)
    );

    always #2 clk = ~clk;

    assign ctrl_dut = {ex_mem_out.valid, ex_mem_out.mem_read, ex_mem_out.mem_write,
                       ex_mem_out.reg_write, ex_mem_out.mem_to_reg};
    assign ctrl_exp = {m_mem.valid, m_mem.mem_read, m_mem.mem_write,
                       m_mem.reg_write, m_mem.mem_to_reg};

    function automatic int pick_below(input int n);
        word_t r;
        r = $random(seed);
        r[31] = 1'b0;   // Keeps the remainder positive
        return int'(r) % n;
    endfunction

    // Data memory contents, every address bit changes the word
    function automatic word_t load_data(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
        logic [4:0] sh;
        word_t      r;
        sh = b[4:0];        // Only five bits of B count for shifts
        case (op)
            ALU_SUB:  r = a - b;
            ALU_SLL:  r = a << sh;
            ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  r = a ^ b;
            ALU_SRL:  r = a >> sh;
            ALU_SRA:  r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0); // Sign copies on top
            ALU_OR:   r = a | b;
            ALU_AND:  r = a & b;
            default:  r = a + b;
        endcase
        return r;
    endfunction

    // Newest value of a source as the instruction in execute must see it
    function automatic word_t fwd_val(input reg_idx_t idx, input word_t rf_val);
        if (idx == '0)
            return rf_val;
        if (m_mem.valid && m_mem.reg_write && !m_mem.mem_read && m_mem.rd_idx == idx)
            return m_mem.result;
        if (m_wb.valid && m_wb.rd_idx == idx)
            return m_wb.value;
        return rf_val;
    endfunction

    function automatic word_t rf_read(input reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (m_wb.valid && m_wb.rd_idx == idx)
            return m_wb.value;  // The write in progress is visible to the read
        return rf[idx];
    endfunction

    function automatic id_ex_t make_instr(input op_class_t cls, input alu_op_t op,
                                          input reg_idx_t rd, input reg_idx_t rs1,
                                          input reg_idx_t rs2, input word_t imm);
        id_ex_t t;
        t = '0;
        t.valid     = 1'b1;
        t.pc        = next_pc;
        t.op_class  = cls;
        t.alu_op    = op;
        t.rd_idx    = rd;
        t.rs1_idx   = rs1;
        t.rs2_idx   = rs2;
        t.imm       = imm;
        t.reg_write = (cls != CLS_BRANCH);
        return t;
    endfunction

    function automatic id_ex_t random_instr();
        id_ex_t t;
        word_t  r;
        r = $random(seed);
        // Registers x0 to x7 only, so dependencies come up often
        t = make_instr(op_class_t'(r[2:0]), ALU_ADD, {2'b00, r[5:3]}, {2'b00, r[8:6]},
                       {2'b00, r[11:9]}, $random(seed));
        if (t.op_class == CLS_ALU_REG || t.op_class == CLS_ALU_IMM)
            t.alu_op = ALU_OPS[4'(pick_below(10))];
        if (t.op_class == CLS_BRANCH)
            t.br_cond = CONDS[3'(pick_below(6))];
        if (t.op_class == CLS_LUI)
            t.imm[11:0] = '0;   // Decode has already shifted the upper immediate
        if (t.op_class == CLS_MEM)
        begin
            t.mem_read   = r[12];   // Load when set, store otherwise
            t.mem_write  = !r[12];
            t.reg_write  = r[12];
            t.mem_to_reg = r[12];
        end
        return t;
    endfunction

    task automatic compute_expected();
        word_t r1;
        word_t r2;
        word_t a;
        word_t b;
        logic  cond;
        logic  jump;
        r1 = fwd_val(m_ex.rs1_idx, m_ex.rs1_val);
        r2 = fwd_val(m_ex.rs2_idx, m_ex.rs2_val);
        a  = r1;
        b  = m_ex.imm;
        case (m_ex.op_class)
            CLS_BRANCH, CLS_ALU_REG: b = r2;
            CLS_LUI:                 a = '0;
            CLS_AUIPC, CLS_JAL:      a = m_ex.pc;
            default:                 b = m_ex.imm;
        endcase
        case (m_ex.br_cond)
            BR_BEQ:  cond = (r1 == r2);
            BR_BNE:  cond = (r1 != r2);
            BR_BLT:  cond = ($signed(r1) < $signed(r2));
            BR_BGE:  cond = ($signed(r1) >= $signed(r2));
            BR_BLTU: cond = (r1 < r2);
            BR_BGEU: cond = (r1 >= r2);
            default: cond = 1'b0;
        endcase
        jump = (m_ex.op_class == CLS_JAL) || (m_ex.op_class == CLS_JALR);
        exp_taken  = m_ex.valid && !stall && (jump || (m_ex.op_class == CLS_BRANCH && cond));
        exp_target = (m_ex.op_class == CLS_JALR) ? ((r1 + m_ex.imm) & 32'hffff_fffe)
                                                 : m_ex.pc + m_ex.imm;
        exp_next.valid      = m_ex.valid;
        exp_next.result     = jump ? m_ex.pc + `PC_STEP : alu_ref(m_ex.alu_op, a, b);
        exp_next.store_data = r2;
        exp_next.rd_idx     = m_ex.rd_idx;
        exp_next.mem_read   = m_ex.valid && m_ex.mem_read;
        exp_next.mem_write  = m_ex.valid && m_ex.mem_write;
        exp_next.reg_write  = m_ex.valid && m_ex.reg_write;
        exp_next.mem_to_reg = m_ex.valid && m_ex.mem_to_reg;
    endtask

    // Moves the model one stage on, mirroring the edge that just passed
    task automatic advance_model();
        if (!stall)
        begin
            if (m_wb.valid && m_wb.rd_idx != '0)
                rf[m_wb.rd_idx] = m_wb.value;
            m_wb.valid  = m_mem.valid && m_mem.reg_write;
            m_wb.rd_idx = m_mem.rd_idx;
            m_wb.value  = m_mem.mem_read ? load_data(m_mem.result) : m_mem.result;
            m_mem = exp_next;
            m_ex  = id_in;
            if (exp_taken)
                m_ex.valid = 1'b0;  // Wrong path behind a taken redirect
        end
    endtask

    task automatic step(input id_ex_t nxt, input logic hold);
        id_ex_t t;
        @(negedge clk);
        advance_model();
        t = nxt;
        t.rs1_val = rf_read(nxt.rs1_idx);
        t.rs2_val = rf_read(nxt.rs2_idx);
        stall = hold;
        id_in = t;
        wb_in = m_wb;
        compute_expected();
    endtask

    // Presents one instruction, held at decode through random stall cycles
    task automatic issue(input id_ex_t instr);
        while (pick_below(8) == 0)
            step(instr, 1'b1);
        step(instr, 1'b0);
        next_pc = exp_taken ? exp_target : next_pc + `PC_STEP;
    endtask

    a_taken: assert property (@(posedge clk) disable iff (rst) redirect.taken == exp_taken)
    else
    begin
        errors++;
        $display("Error: redirect.taken expected %h, got %h",
                 $sampled(exp_taken), $sampled(redirect.taken));
    end

    a_target: assert property (@(posedge clk) disable iff (rst)
                               !exp_taken || redirect.target == exp_target)
    else
    begin
        errors++;
        $display("Error: redirect.target expected %h, got %h",
                 $sampled(exp_target), $sampled(redirect.target));
    end

    a_ctrl: assert property (@(posedge clk) disable iff (rst) ctrl_dut == ctrl_exp)
    else
    begin
        errors++;
        $display("Error: ex_mem_out control bits expected %h, got %h",
                 $sampled(ctrl_exp), $sampled(ctrl_dut));
    end

    a_result: assert property (@(posedge clk) disable iff (rst)
                               !m_mem.valid || ex_mem_out.result == m_mem.result)
    else
    begin
        errors++;
        $display("Error: ex_mem_out.result expected %h, got %h",
                 $sampled(m_mem.result), $sampled(ex_mem_out.result));
    end

    a_store: assert property (@(posedge clk) disable iff (rst)
                              !m_mem.valid || ex_mem_out.store_data == m_mem.store_data)
    else
    begin
        errors++;
        $display("Error: ex_mem_out.store_data expected %h, got %h",
                 $sampled(m_mem.store_data), $sampled(ex_mem_out.store_data));
    end

    a_rd: assert property (@(posedge clk) disable iff (rst)
                           !m_mem.valid || ex_mem_out.rd_idx == m_mem.rd_idx)
    else
    begin
        errors++;
        $display("Error: ex_mem_out.rd_idx expected %h, got %h",
                 $sampled(m_mem.rd_idx), $sampled(ex_mem_out.rd_idx));
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b1;
        stall       = 1'b0;
        id_in       = '0;
        wb_in       = '0;
        seed        = 32'h50577690;
        errors      = 0;
        cycle_count = 0;
        next_pc     = 32'h0000_1000;
        m_ex        = '0;
        m_mem       = '0;
        m_wb        = '0;
        exp_next    = '0;
        exp_taken   = 1'b0;
        exp_target  = '0;
        rf[0]       = '0;
        for (int i = 1; i < 32; i++)
            rf[i[4:0]] = $random(seed);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compute_expected();
        repeat (3) step('0, 1'b0);  // Bubbles only, outputs must stay at their reset values
        issue(make_instr(CLS_ALU_IMM, ALU_ADD, 5'd1, 5'd0, 5'd0, 32'h100));
        issue(make_instr(CLS_ALU_REG, ALU_ADD, 5'd2, 5'd1, 5'd1, '0));   // Both from EX/MEM
        issue(make_instr(CLS_ALU_REG, ALU_SUB, 5'd3, 5'd2, 5'd1, '0));   // x1 via writeback
        issue(make_instr(CLS_ALU_IMM, ALU_ADD, 5'd0, 5'd3, 5'd0, 32'h5)); // Write to x0
        issue(make_instr(CLS_ALU_REG, ALU_OR, 5'd4, 5'd0, 5'd0, '0));
        issue(make_instr(CLS_JALR, ALU_ADD, 5'd5, 5'd3, 5'd0, 32'h3));    // Odd target
        issue(make_instr(CLS_ALU_IMM, ALU_ADD, 5'd6, 5'd5, 5'd0, 32'h1)); // Gets flushed
        repeat (NUM_RANDOM) issue(random_instr());
        repeat (4) step('0, 1'b0);  // Drain the pipeline
        @(negedge clk);
        $display("Execute cluster checks done with %0d errors", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule
